/* design/game_pkg.sv */
// game package: screen geometry, ps/2 scan codes and ship command types
package game_pkg;

	// screen geometry
	localparam int SCREEN_WIDTH  = 160; // columns
	localparam int SCREEN_HEIGHT = 120; // rows

	typedef logic [7:0] x_coord_t; // column 0..159
	typedef logic [6:0] y_coord_t; // row 0..119, grows downward
	typedef logic [2:0] colour_t;  // {r, g, b}, one bit each

	localparam colour_t COLOUR_WHITE = 3'b111;
	localparam colour_t COLOUR_BLACK = 3'b000;

	// ship spawn point, middle of the screen
	localparam x_coord_t SHIP_START_X = 8'd80;
	localparam y_coord_t SHIP_START_Y = 7'd60;

	// ps/2 link
	localparam int FILTER_LEN     = 8;  // equal ps2c samples before the level moves
	localparam int PS2_FRAME_BITS = 11; // start, 8 data, parity, stop

	typedef logic [7:0] scan_code_t;

	// set 2 codes used by the game
	localparam scan_code_t SC_BREAK     = 8'hf0; // release prefix
	localparam scan_code_t SC_KEY_A     = 8'h1c; // left
	localparam scan_code_t SC_KEY_D     = 8'h23; // right
	localparam scan_code_t SC_KEY_S     = 8'h1b; // down
	localparam scan_code_t SC_KEY_W     = 8'h1d; // up
	localparam scan_code_t SC_KEY_SPACE = 8'h29; // fire

	// held key decoded into a ship command
	typedef enum logic [2:0]
	{
		cmd_none,
		cmd_left,
		cmd_right,
		cmd_down,
		cmd_up,
		cmd_fire
	} ship_cmd_t;

	// last direction the ship moved in, also the bullet's travel direction
	typedef enum logic [1:0]
	{
		head_left,
		head_right,
		head_down,
		head_up
	} heading_t;

endpackage

/* design/ps2_receiver.sv */
// ps/2 receiver: glitch-filters the keyboard clock and shifts in one 11-bit frame per code
module ps2_receiver
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 ps2c,
	input  logic                 ps2d,
	output game_pkg::scan_code_t scan_code,
	output logic                 scan_valid
);

	typedef enum logic {rx_idle, rx_shift} rx_state_t;

	rx_state_t state;
	logic [game_pkg::FILTER_LEN-1:0] filt_sr; // newest sample at the top
	logic filt_level; // debounced ps2c
	logic filt_next;
	logic fall; // filtered ps2c going low
	logic [$clog2(game_pkg::PS2_FRAME_BITS+1)-1:0] bit_cnt; // edges taken this frame
	logic [game_pkg::PS2_FRAME_BITS-1:0] frame_sr; // lsb first, start bit ends at bit 0

	// level only moves once all samples agree
	always_comb
	begin
		filt_next = filt_level;
		if (filt_sr == '1)
			filt_next = 1'b1;
		else if (filt_sr == '0)
			filt_next = 1'b0;
	end

	assign fall = filt_level & ~filt_next;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			filt_sr    <= '1; // ps2c idles high
			filt_level <= 1'b1;
		end
		else
		begin
			filt_sr    <= {ps2c, filt_sr[game_pkg::FILTER_LEN-1:1]};
			filt_level <= filt_next;
		end
	end

	// every falling edge carries a bit, the start bit included
	always_ff @(posedge clock)
	begin
		if (fall)
			frame_sr <= {ps2d, frame_sr[game_pkg::PS2_FRAME_BITS-1:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state      <= rx_idle;
			bit_cnt    <= '0;
			scan_valid <= 1'b0;
		end
		else
		begin
			scan_valid <= 1'b0; // one cycle only
			case (state)
				rx_idle:
					if (fall) // start bit
					begin
						bit_cnt <= 1;
						state   <= rx_shift;
					end
				rx_shift:
					if (fall)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (int'(bit_cnt) == game_pkg::PS2_FRAME_BITS - 1) // stop bit
						begin
							scan_valid <= 1'b1;
							state      <= rx_idle;
						end
					end
				default:
					state <= rx_idle;
			endcase
		end
	end

	assign scan_code = frame_sr[8:1]; // parity ignored
endmodule

/* design/key_tracker.sv */
// key tracker: follows make and break codes and holds the command of the pressed key
module key_tracker
(
	input  logic                 clock,
	input  logic                 reset,
	input  game_pkg::scan_code_t scan_code,
	input  logic                 scan_valid,
	output game_pkg::ship_cmd_t  ship_cmd
);

	typedef enum logic {track_make, track_break} track_state_t;

	track_state_t state; // track_break waits for the released code
	game_pkg::scan_code_t held_code; // key that set ship_cmd
	game_pkg::ship_cmd_t key_cmd; // decode of the incoming code

	// scan code to command map
	always_comb
	begin
		case (scan_code)
			game_pkg::SC_KEY_A:     key_cmd = game_pkg::cmd_left;
			game_pkg::SC_KEY_D:     key_cmd = game_pkg::cmd_right;
			game_pkg::SC_KEY_S:     key_cmd = game_pkg::cmd_down;
			game_pkg::SC_KEY_W:     key_cmd = game_pkg::cmd_up;
			game_pkg::SC_KEY_SPACE: key_cmd = game_pkg::cmd_fire;
			default:                key_cmd = game_pkg::cmd_none; // not a game key
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state     <= track_make;
			ship_cmd  <= game_pkg::cmd_none;
			held_code <= '0; // 00 is never a game key
		end
		else if (scan_valid)
		begin
			case (state)
				track_make:
					if (scan_code == game_pkg::SC_BREAK)
						state <= track_break;
					else if (key_cmd != game_pkg::cmd_none) // newest press wins
					begin
						ship_cmd  <= key_cmd;
						held_code <= scan_code;
					end
				track_break:
				begin
					// release of some other key leaves the command alone
					if (scan_code == held_code)
						ship_cmd <= game_pkg::cmd_none;
					state <= track_make; // code after F0 is always consumed
				end
				default:
					state <= track_make;
			endcase
		end
	end
endmodule

/* design/raster_scanner.sv */
// raster scanner: walks the 160x120 screen one pixel per clock and flags the last pixel
module raster_scanner
(
	input  logic               clock,
	input  logic               reset,
	output game_pkg::x_coord_t scan_x,
	output game_pkg::y_coord_t scan_y,
	output logic               frame_end
);

	logic last_col; // x at 159
	logic last_row; // y at 119

	assign last_col = (scan_x == game_pkg::x_coord_t'(game_pkg::SCREEN_WIDTH - 1));
	assign last_row = (scan_y == game_pkg::y_coord_t'(game_pkg::SCREEN_HEIGHT - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			scan_x <= '0;
			scan_y <= '0;
		end
		else if (last_col)
		begin
			scan_x <= '0;
			if (last_row)
				scan_y <= '0; // wrap to top left
			else
				scan_y <= scan_y + 1'b1;
		end
		else
			scan_x <= scan_x + 1'b1; // x first
	end

	// game tick, once every 19200 clocks
	assign frame_end = last_col & last_row;
endmodule

/* design/ship_mover.sv */
// ship mover: steps the ship one pixel per frame in the held direction, stopping at edges
module ship_mover
(
	input  logic                clock,
	input  logic                reset,
	input  logic                frame_end,
	input  game_pkg::ship_cmd_t ship_cmd,
	output game_pkg::x_coord_t  ship_x,
	output game_pkg::y_coord_t  ship_y,
	output game_pkg::heading_t  heading
);

	logic at_left;
	logic at_right;
	logic at_top;
	logic at_bottom;

	assign at_left   = (ship_x == '0);
	assign at_right  = (ship_x == game_pkg::x_coord_t'(game_pkg::SCREEN_WIDTH - 1));
	assign at_top    = (ship_y == '0);
	assign at_bottom = (ship_y == game_pkg::y_coord_t'(game_pkg::SCREEN_HEIGHT - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ship_x  <= game_pkg::SHIP_START_X;
			ship_y  <= game_pkg::SHIP_START_Y;
			heading <= game_pkg::head_up;
		end
		else if (frame_end)
		begin
			// heading follows the command even when pinned at an edge
			case (ship_cmd)
				game_pkg::cmd_left:
				begin
					heading <= game_pkg::head_left;
					if (!at_left)
						ship_x <= ship_x - 1'b1;
				end
				game_pkg::cmd_right:
				begin
					heading <= game_pkg::head_right;
					if (!at_right)
						ship_x <= ship_x + 1'b1;
				end
				game_pkg::cmd_down:
				begin
					heading <= game_pkg::head_down;
					if (!at_bottom)
						ship_y <= ship_y + 1'b1; // y grows downward
				end
				game_pkg::cmd_up:
				begin
					heading <= game_pkg::head_up;
					if (!at_top)
						ship_y <= ship_y - 1'b1;
				end
				default:
					; // none or fire, ship holds still
			endcase
		end
	end
endmodule

/* design/bullet_mover.sv */
// bullet mover: launches one bullet from the ship, flies it per frame and retires it at the edge
module bullet_mover
(
	input  logic                clock,
	input  logic                reset,
	input  logic                frame_end,
	input  game_pkg::ship_cmd_t ship_cmd,
	input  game_pkg::x_coord_t  ship_x,
	input  game_pkg::y_coord_t  ship_y,
	input  game_pkg::heading_t  heading,
	output game_pkg::x_coord_t  bullet_x,
	output game_pkg::y_coord_t  bullet_y,
	output logic                bullet_active
);

	game_pkg::heading_t bullet_dir; // frozen at launch
	logic at_edge; // next step would leave the screen

	always_comb
	begin
		case (bullet_dir)
			game_pkg::head_left:
				at_edge = (bullet_x == '0);
			game_pkg::head_right:
				at_edge = (bullet_x == game_pkg::x_coord_t'(game_pkg::SCREEN_WIDTH - 1));
			game_pkg::head_down:
				at_edge = (bullet_y == game_pkg::y_coord_t'(game_pkg::SCREEN_HEIGHT - 1));
			default:
				at_edge = (bullet_y == '0); // head_up
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			bullet_active <= 1'b0;
		else if (frame_end)
		begin
			if (!bullet_active)
				bullet_active <= (ship_cmd == game_pkg::cmd_fire); // one in flight at most
			else if (at_edge)
				bullet_active <= 1'b0; // relaunch possible on the next tick
		end
	end

	// position tracks the ship while idle, so launch lands on the ship
	always_ff @(posedge clock)
	begin
		if (frame_end)
		begin
			if (!bullet_active)
			begin
				bullet_x   <= ship_x;
				bullet_y   <= ship_y;
				bullet_dir <= heading;
			end
			else if (!at_edge)
			begin
				case (bullet_dir)
					game_pkg::head_left:  bullet_x <= bullet_x - 1'b1;
					game_pkg::head_right: bullet_x <= bullet_x + 1'b1;
					game_pkg::head_down:  bullet_y <= bullet_y + 1'b1;
					default:              bullet_y <= bullet_y - 1'b1;
				endcase
			end
		end
	end
endmodule

/* design/pixel_painter.sv */
// pixel painter: colours each scanned pixel white on a sprite and black elsewhere, registered
module pixel_painter
(
	input  logic                clock,
	input  logic                reset,
	input  game_pkg::x_coord_t  scan_x,
	input  game_pkg::y_coord_t  scan_y,
	input  game_pkg::x_coord_t  ship_x,
	input  game_pkg::y_coord_t  ship_y,
	input  game_pkg::x_coord_t  bullet_x,
	input  game_pkg::y_coord_t  bullet_y,
	input  logic                bullet_active,
	output game_pkg::x_coord_t  pixel_x,
	output game_pkg::y_coord_t  pixel_y,
	output game_pkg::colour_t   pixel_colour,
	output logic                pixel_plot
);

	logic ship_hit;
	logic bullet_hit; // only a live bullet is drawn

	assign ship_hit   = (scan_x == ship_x) && (scan_y == ship_y);
	assign bullet_hit = bullet_active && (scan_x == bullet_x) && (scan_y == bullet_y);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pixel_x      <= '0;
			pixel_y      <= '0;
			pixel_colour <= game_pkg::COLOUR_BLACK;
			pixel_plot   <= 1'b0;
		end
		else
		begin
			pixel_x      <= scan_x;
			pixel_y      <= scan_y;
			pixel_colour <= (ship_hit || bullet_hit) ? game_pkg::COLOUR_WHITE
			                                         : game_pkg::COLOUR_BLACK;
			pixel_plot   <= 1'b1; // every pixel gets written, every clock
		end
	end
endmodule

/* design/ship_game.sv */
// ship game top: keyboard in, sprite pixels out, through receiver, tracker, movers and painter
module ship_game
(
	input  logic               clock,
	input  logic               reset,
	input  logic               ps2c,
	input  logic               ps2d,
	output game_pkg::x_coord_t pixel_x,
	output game_pkg::y_coord_t pixel_y,
	output game_pkg::colour_t  pixel_colour,
	output logic               pixel_plot
);

	game_pkg::scan_code_t scan_code;
	logic                 scan_valid;
	game_pkg::ship_cmd_t  ship_cmd; // held key, as a level
	game_pkg::x_coord_t   scan_x;
	game_pkg::y_coord_t   scan_y;
	logic                 frame_end; // movement tick
	game_pkg::x_coord_t   ship_x;
	game_pkg::y_coord_t   ship_y;
	game_pkg::heading_t   heading;
	game_pkg::x_coord_t   bullet_x;
	game_pkg::y_coord_t   bullet_y;
	logic                 bullet_active;

	ps2_receiver i_ps2_receiver (
		.clock      (clock),
		.reset      (reset),
		.ps2c       (ps2c),
		.ps2d       (ps2d),
		.scan_code  (scan_code),
		.scan_valid (scan_valid)
	);

	key_tracker i_key_tracker (
		.clock      (clock),
		.reset      (reset),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.ship_cmd   (ship_cmd)
	);

	raster_scanner i_raster_scanner (
		.clock     (clock),
		.reset     (reset),
		.scan_x    (scan_x),
		.scan_y    (scan_y),
		.frame_end (frame_end)
	);

	ship_mover i_ship_mover (
		.clock     (clock),
		.reset     (reset),
		.frame_end (frame_end),
		.ship_cmd  (ship_cmd),
		.ship_x    (ship_x),
		.ship_y    (ship_y),
		.heading   (heading)
	);

	bullet_mover i_bullet_mover (
		.clock         (clock),
		.reset         (reset),
		.frame_end     (frame_end),
		.ship_cmd      (ship_cmd),
		.ship_x        (ship_x),
		.ship_y        (ship_y),
		.heading       (heading),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active)
	);

	pixel_painter i_pixel_painter (
		.clock         (clock),
		.reset         (reset),
		.scan_x        (scan_x),
		.scan_y        (scan_y),
		.ship_x        (ship_x),
		.ship_y        (ship_y),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active),
		.pixel_x       (pixel_x),
		.pixel_y       (pixel_y),
		.pixel_colour  (pixel_colour),
		.pixel_plot    (pixel_plot)
	);
endmodule

/* verification/ship_game_properties.sv */
// ship game properties: range, colour and reset checks on the painted pixel stream
module ship_game_properties
(
	input logic               clock,
	input logic               reset,
	input game_pkg::x_coord_t pixel_x,
	input game_pkg::y_coord_t pixel_y,
	input game_pkg::colour_t  pixel_colour,
	input logic               pixel_plot
);
	timeunit 1ns;
	timeprecision 1ps;

	x_on_screen: assert property (@(posedge clock) disable iff (reset)
		pixel_plot |-> int'(pixel_x) < game_pkg::SCREEN_WIDTH)
		else $error("pixel_x beyond the last column");

	y_on_screen: assert property (@(posedge clock) disable iff (reset)
		pixel_plot |-> int'(pixel_y) < game_pkg::SCREEN_HEIGHT)
		else $error("pixel_y beyond the last row");

	// sprites are white, background black, nothing else
	two_colours: assert property (@(posedge clock) disable iff (reset)
		pixel_colour == game_pkg::COLOUR_WHITE || pixel_colour == game_pkg::COLOUR_BLACK)
		else $error("pixel_colour neither white nor black");

	quiet_in_reset: assert property (@(posedge clock) reset |-> !pixel_plot)
		else $error("pixel_plot high during reset");
endmodule

bind ship_game ship_game_properties i_ship_game_properties (
	.clock        (clock),
	.reset        (reset),
	.pixel_x      (pixel_x),
	.pixel_y      (pixel_y),
	.pixel_colour (pixel_colour),
	.pixel_plot   (pixel_plot)
);

/* verification/ship_game_tb.sv */
// ship game testbench: types keys over ps/2, models ship and bullet, checks every painted frame
module ship_game_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_NS     = 4;
	localparam int HALF_BIT     = 20; // ps2c half period, clocks
	localparam int FRAME_CYCLES = game_pkg::SCREEN_WIDTH * game_pkg::SCREEN_HEIGHT;
	localparam int PLAN_FRAMES  = 209; // sum of all test waits below
	localparam int SLACK_FRAMES = 10;

	// expected game state between two frame ticks
	typedef struct packed
	{
		int                 ship_x;
		int                 ship_y;
		game_pkg::heading_t heading;
		int                 bullet_x;
		int                 bullet_y;
		game_pkg::heading_t bullet_dir;
		bit                 bullet_active;
	} game_state_t;

	logic                clock;
	logic                reset;
	logic                ps2c;
	logic                ps2d;
	game_pkg::x_coord_t  pixel_x;
	game_pkg::y_coord_t  pixel_y;
	game_pkg::colour_t   pixel_colour;
	logic                pixel_plot;

	logic [23:0]          lfsr;
	bit                   glitch_on; // short ps2c pulses during high phases
	bit                   in_transit; // key bytes still on the wire
	game_pkg::ship_cmd_t  model_cmd; // command the keyboard should have set
	game_pkg::scan_code_t model_held;
	bit                   model_break;
	game_state_t          model; // state shown by the frame being painted
	bit                   frame_dirty; // painted after an uncertain tick
	int                   seen_frame [FRAME_CYCLES]; // frame id each pixel last came in
	int                   white_x [$];
	int                   white_y [$];
	int                   last_white_x;
	int                   prev_whites; // white pixels in the previous frame
	int                   pixel_count;
	int                   frames;
	int                   checks;
	int                   errors;
	int                   launches;
	int                   resyncs;
	int                   tests;
	event                 frame_done;

	ship_game i_ship_game (
		.clock        (clock),
		.reset        (reset),
		.ps2c         (ps2c),
		.ps2d         (ps2d),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.pixel_colour (pixel_colour),
		.pixel_plot   (pixel_plot)
	);

	initial
		clock = 1'b0;
	always #(CLOCK_NS / 2) clock = ~clock;

	// 24-bit fibonacci, taps 24 23 22 17
	function automatic logic [23:0] lfsr_next(logic [23:0] s);
		return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		repeat (n)
		begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | int'(lfsr[0]); // one step per bit
		end
	endtask

	function automatic int step_x(game_pkg::heading_t h);
		return (h == game_pkg::head_left) ? -1 : ((h == game_pkg::head_right) ? 1 : 0);
	endfunction

	function automatic int step_y(game_pkg::heading_t h);
		return (h == game_pkg::head_up) ? -1 : ((h == game_pkg::head_down) ? 1 : 0);
	endfunction

	function automatic bit on_screen(int x, int y);
		return x >= 0 && x < game_pkg::SCREEN_WIDTH && y >= 0 && y < game_pkg::SCREEN_HEIGHT;
	endfunction

	// one frame tick: ship steps with saturation, bullet launches, flies or retires
	function automatic game_state_t ref_step(game_state_t s, game_pkg::ship_cmd_t cmd);
		game_state_t        n;
		game_pkg::heading_t dir;
		bit                 steer;
		int                 nx;
		int                 ny;
		n     = s;
		steer = 1'b1;
		dir   = s.heading;
		case (cmd)
			game_pkg::cmd_left:  dir = game_pkg::head_left;
			game_pkg::cmd_right: dir = game_pkg::head_right;
			game_pkg::cmd_down:  dir = game_pkg::head_down;
			game_pkg::cmd_up:    dir = game_pkg::head_up;
			default:             steer = 1'b0; // none or fire
		endcase
		if (steer)
		begin
			n.heading = dir; // turns even when pinned
			nx = s.ship_x + step_x(dir);
			ny = s.ship_y + step_y(dir);
			if (on_screen(nx, ny))
			begin
				n.ship_x = nx;
				n.ship_y = ny;
			end
		end
		if (!s.bullet_active)
		begin
			if (cmd == game_pkg::cmd_fire)
			begin
				n.bullet_active = 1'b1;
				n.bullet_x      = s.ship_x; // ship as it stood before the tick
				n.bullet_y      = s.ship_y;
				n.bullet_dir    = s.heading;
			end
		end
		else
		begin
			nx = s.bullet_x + step_x(s.bullet_dir);
			ny = s.bullet_y + step_y(s.bullet_dir);
			if (on_screen(nx, ny))
			begin
				n.bullet_x = nx;
				n.bullet_y = ny;
			end
			else
				n.bullet_active = 1'b0;
		end
		return n;
	endfunction

	function automatic game_pkg::ship_cmd_t key_command(game_pkg::scan_code_t code);
		case (code)
			game_pkg::SC_KEY_A:     return game_pkg::cmd_left;
			game_pkg::SC_KEY_D:     return game_pkg::cmd_right;
			game_pkg::SC_KEY_S:     return game_pkg::cmd_down;
			game_pkg::SC_KEY_W:     return game_pkg::cmd_up;
			game_pkg::SC_KEY_SPACE: return game_pkg::cmd_fire;
			default:                return game_pkg::cmd_none;
		endcase
	endfunction

	// expected effect of one received code on the held command
	task automatic track_code(input game_pkg::scan_code_t code);
		if (model_break)
		begin
			if (code == model_held)
				model_cmd = game_pkg::cmd_none;
			model_break = 1'b0;
		end
		else if (code == game_pkg::SC_BREAK)
			model_break = 1'b1;
		else if (key_command(code) != game_pkg::cmd_none)
		begin
			model_cmd  = key_command(code);
			model_held = code;
		end
	endtask

	// high half period, maybe with a low pulse shorter than the filter
	task automatic hold_high();
		int hit;
		int width;
		hit   = 0;
		width = 0;
		if (glitch_on)
			take_bits(1, hit);
		if (hit != 0)
		begin
			take_bits(3, width);
			width = width % (game_pkg::FILTER_LEN - 2) + 1; // 1..6 clocks
			repeat (game_pkg::FILTER_LEN + 1) @(negedge clock); // filtered level already high
			ps2c = 1'b0;
			repeat (width) @(negedge clock);
			ps2c = 1'b1;
			repeat (HALF_BIT - game_pkg::FILTER_LEN - 1 - width) @(negedge clock);
		end
		else
			repeat (HALF_BIT) @(negedge clock);
	endtask

	task automatic send_bit(input logic value);
		ps2d = value; // changes while ps2c is high
		hold_high();
		ps2c = 1'b0;
		repeat (HALF_BIT) @(negedge clock);
		ps2c = 1'b1;
	endtask

	task automatic send_code(input game_pkg::scan_code_t code);
		int gap;
		int i;
		take_bits(8, gap);
		repeat (gap + 4) @(negedge clock); // random idle between keys
		@(posedge clock);
		in_transit = 1'b1;
		@(negedge clock);
		send_bit(1'b0); // start
		for (i = 0; i < 8; i++)
			send_bit(code[i]); // lsb first
		send_bit(~^code); // odd parity
		send_bit(1'b1); // stop
		hold_high(); // filter and tracker settle
		@(posedge clock);
		track_code(code);
		in_transit = 1'b0;
	endtask

	// keys go out right after a frame so they land well before the next tick
	task automatic press_key(input game_pkg::scan_code_t code);
		@(frame_done);
		send_code(code);
	endtask

	task automatic release_key(input game_pkg::scan_code_t code);
		@(frame_done);
		send_code(game_pkg::SC_BREAK);
		send_code(code);
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(frame_done);
	endtask

	task automatic check_pixel(input int x, input int y, input game_pkg::colour_t colour);
		int idx;
		bit want_white;
		checks++;
		if (x >= game_pkg::SCREEN_WIDTH || y >= game_pkg::SCREEN_HEIGHT)
		begin
			errors++;
			$display("** Error at %0t: pixel (%0d,%0d) is off the screen", $time, x, y);
		end
		else
		begin
			idx = y * game_pkg::SCREEN_WIDTH + x;
			if (seen_frame[idx] == frames)
			begin
				errors++;
				$display("** Error at %0t: pixel (%0d,%0d) painted twice", $time, x, y);
			end
			seen_frame[idx] = frames;
			pixel_count++;
			if (colour == game_pkg::COLOUR_WHITE)
			begin
				white_x.push_back(x);
				white_y.push_back(y);
			end
			want_white = (x == model.ship_x && y == model.ship_y) || (model.bullet_active
				&& x == model.bullet_x && y == model.bullet_y);
			if (!frame_dirty && colour != (want_white ? game_pkg::COLOUR_WHITE
				: game_pkg::COLOUR_BLACK))
			begin
				errors++;
				$display("** Error at %0t: pixel (%0d,%0d) colour %b, expected white %0d",
					$time, x, y, colour, want_white);
			end
		end
	endtask

	// take the ship from the first white pixel that is not the bullet
	task automatic resync_ship();
		int i;
		bit found;
		found = 1'b0;
		for (i = 0; i < white_x.size(); i++)
		begin
			if (!found && !(model.bullet_active && white_x[i] == model.bullet_x
				&& white_y[i] == model.bullet_y))
			begin
				found = 1'b1;
				if (white_x[i] < model.ship_x)
					model.heading = game_pkg::head_left;
				else if (white_x[i] > model.ship_x)
					model.heading = game_pkg::head_right;
				else if (white_y[i] > model.ship_y)
					model.heading = game_pkg::head_down;
				else if (white_y[i] < model.ship_y)
					model.heading = game_pkg::head_up;
				model.ship_x = white_x[i];
				model.ship_y = white_y[i];
			end
		end
		resyncs++;
	endtask

	task automatic close_frame();
		game_state_t next;
		checks++;
		if (pixel_count != FRAME_CYCLES)
		begin
			errors++;
			$display("** Error at %0t: frame %0d painted %0d of %0d pixels",
				$time, frames, pixel_count, FRAME_CYCLES);
		end
		if (white_x.size() > 0)
			last_white_x = white_x[0];
		if (white_x.size() > 1 && prev_whites < 2)
			launches++; // bullet seen apart from the ship
		prev_whites = white_x.size();
		if (frame_dirty)
			resync_ship();
		next        = ref_step(model, model_cmd);
		model       = next;
		frame_dirty = in_transit; // tick may have seen either command
		white_x.delete();
		white_y.delete();
		pixel_count = 0;
		frames++;
		->frame_done;
	endtask

	// compare process, outputs are stable at the falling edge
	always @(negedge clock)
	begin
		if (!reset && pixel_plot)
		begin
			check_pixel(int'(pixel_x), int'(pixel_y), pixel_colour);
			if (int'(pixel_x) == game_pkg::SCREEN_WIDTH - 1
				&& int'(pixel_y) == game_pkg::SCREEN_HEIGHT - 1)
				close_frame();
		end
	end

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	initial
	begin
		int mark;
		reset       = 1'b1;
		ps2c        = 1'b1; // idle bus
		ps2d        = 1'b1;
		lfsr        = 24'd86260;
		glitch_on   = 1'b0;
		in_transit  = 1'b0;
		model_cmd   = game_pkg::cmd_none;
		model_held  = '0;
		model_break = 1'b0;
		frame_dirty = 1'b0;
		prev_whites = 0;
		model.ship_x        = int'(game_pkg::SHIP_START_X);
		model.ship_y        = int'(game_pkg::SHIP_START_Y);
		model.heading       = game_pkg::head_up;
		model.bullet_x      = 0;
		model.bullet_y      = 0;
		model.bullet_dir    = game_pkg::head_up;
		model.bullet_active = 1'b0;
		foreach (seen_frame[i])
			seen_frame[i] = -1;
		{pixel_count, frames, checks, errors, launches, resyncs, tests, last_white_x} = '0;
		repeat (5) @(negedge clock);
		reset = 1'b0;

		mark = errors;
		wait_frames(3);
		report_test("ship alone at start", mark);

		mark = errors;
		glitch_on = 1'b1;
		press_key(game_pkg::SC_KEY_W);
		wait_frames(5);
		press_key(game_pkg::SC_KEY_D); // newest press takes over
		wait_frames(5);
		release_key(game_pkg::SC_KEY_D);
		wait_frames(2);
		glitch_on = 1'b0;
		report_test("up and right with ps2c glitches", mark);

		mark = errors;
		press_key(game_pkg::SC_KEY_S);
		wait_frames(2);
		release_key(game_pkg::SC_KEY_W); // not the held key
		wait_frames(2);
		press_key(8'h15); // unmapped
		wait_frames(2);
		release_key(game_pkg::SC_KEY_S);
		wait_frames(3);
		report_test("release and unmapped codes", mark);

		mark = errors;
		press_key(game_pkg::SC_KEY_A);
		wait_frames(95); // far enough to pin at column 0
		checks++;
		if (last_white_x != 0)
		begin
			errors++;
			$display("** Error at %0t: ship at column %0d after holding left, expected 0",
				$time, last_white_x);
		end
		release_key(game_pkg::SC_KEY_A);
		wait_frames(1);
		report_test("left edge saturation", mark);

		mark = errors;
		press_key(game_pkg::SC_KEY_W);
		wait_frames(2);
		release_key(game_pkg::SC_KEY_W);
		press_key(game_pkg::SC_KEY_SPACE);
		wait_frames(72); // flight to the top edge, retire, relaunch
		checks++;
		if (launches < 2)
		begin
			errors++;
			$display("the bullet did not retire and launch again while fire was held");
		end
		release_key(game_pkg::SC_KEY_SPACE);
		wait_frames(2);
		report_test("bullet flight and relaunch", mark);

		$display("%0d tests, %0d frames, %0d checks, %0d errors, %0d resyncs",
			tests, frames, checks, errors, resyncs);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog over all planned frames plus slack
	initial
	begin
		#((PLAN_FRAMES + SLACK_FRAMES) * FRAME_CYCLES * CLOCK_NS);
		$display("timeout: the tests did not finish within %0d frames",
			PLAN_FRAMES + SLACK_FRAMES);
		$display("Verification failed");
		$finish;
	end
endmodule

/* ship_game.f */
design/game_pkg.sv
design/ps2_receiver.sv
design/key_tracker.sv
design/raster_scanner.sv
design/ship_mover.sv
design/bullet_mover.sv
design/pixel_painter.sv
design/ship_game.sv
verification/ship_game_properties.sv
verification/ship_game_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ship game testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module ship_game_tb -f ship_game.f -Mdir obj_dir \
	&& ./obj_dir/Vship_game_tb | tee /dev/stderr | grep -q "Verification passed" \
	&& { echo "simulation run: pass"; exit 0; } \
	|| { echo "simulation run: fail"; exit 1; }
